//--- hw/huff_defs.svh
`ifndef HUFF_DEFS_SVH
`define HUFF_DEFS_SVH

// datapath widths
`define HUFF_COEF_W   16
`define HUFF_IDX_W    6
`define HUFF_CAT_W    4
`define HUFF_CODE_W   16
`define HUFF_CLEN_W   5
`define HUFF_WORD_W   32
`define HUFF_WLEN_W   6
`define HUFF_RUN_W    6

// block layout and run-length limits
`define HUFF_LAST_IDX 6'd63
`define HUFF_ZRL_RUN  6'd16
`define HUFF_SYM_ZRL  8'hF0
`define HUFF_SYM_EOB  8'h00

`endif

//--- hw/huff_pkg.sv
`include "huff_defs.svh"

package huff_pkg;

    // coefficient side
    typedef logic signed [`HUFF_COEF_W-1:0] coef_t;
    typedef logic [`HUFF_IDX_W-1:0]         zz_index_t;
    typedef logic [`HUFF_CAT_W-1:0]         category_t;
    typedef logic [`HUFF_COEF_W-1:0]        mag_bits_t;
    typedef logic [`HUFF_RUN_W-1:0]         run_t;

    // run in the upper nibble, category in the lower one
    typedef logic [2*`HUFF_CAT_W-1:0]       symbol_t;

    // code and output side
    typedef logic [`HUFF_CODE_W-1:0]        huff_code_t;
    typedef logic [`HUFF_CLEN_W-1:0]        code_len_t;
    typedef logic [`HUFF_WORD_W-1:0]        code_word_t;
    typedef logic [`HUFF_WLEN_W-1:0]        word_len_t;

    typedef enum logic {
        st_idle,
        st_fetch
    } fetch_state_t;

endpackage

//--- hw/coef_decoder.sv
`timescale 1ns/10ps
`include "huff_defs.svh"

module coef_decoder
    import huff_pkg::*;
(
    input  logic      clock,
    input  logic      nreset,
    input  logic      start,
    input  logic      rewind,
    input  zz_index_t rewind_index,
    input  coef_t     coef_in,
    output zz_index_t fetch_addr,
    output logic      dec_valid,
    output zz_index_t dec_index,
    output category_t dec_cat,
    output mag_bits_t dec_mag,
    output logic      fetch_done
);

    fetch_state_t state;
    zz_index_t    fetch_idx;
    logic         v1;
    zz_index_t    idx1;
    coef_t        dc_pred;

    coef_t     diff;
    coef_t     abs_val;
    category_t cat;
    mag_bits_t mask;
    mag_bits_t mag;

    assign fetch_addr = fetch_idx;
    assign fetch_done = (state == st_fetch) && (fetch_idx == `HUFF_LAST_IDX) && !rewind;

    //////////////////////////////
    // fetch sequencer
    always_ff @(posedge clock) begin
        if (nreset) begin
            state     <= st_idle;
            fetch_idx <= '0;
            v1        <= 1'b0;
            dec_valid <= 1'b0;
            dc_pred   <= '0;
        end else begin
            if (rewind) begin
                state     <= st_fetch;
                fetch_idx <= rewind_index;
            end else if (start) begin
                state     <= st_fetch;
                fetch_idx <= '0;
            end else if (fetch_done) begin
                state <= st_idle;
            end else if (state == st_fetch) begin
                fetch_idx <= fetch_idx + 1'b1;
            end
            // a rewind drops both items still in flight
            v1        <= (state == st_fetch) && !rewind;
            dec_valid <= v1 && !rewind;
            if (v1 && (idx1 == '0) && !rewind) begin
                dc_pred <= coef_in;
            end
        end
    end

    //////////////////////////////
    // category and magnitude bits
    always_comb begin
        diff    = (idx1 == '0) ? coef_t'(coef_in - dc_pred) : coef_in;
        abs_val = diff[`HUFF_COEF_W-1] ? coef_t'(-diff) : diff;
        cat     = '0;
        for (int b = 0; b < `HUFF_COEF_W; b++) begin
            if (abs_val[b]) begin
                cat = category_t'(b + 1);
            end
        end
        mask = ~({`HUFF_COEF_W{1'b1}} << cat);
        // negative values send the low bits of value minus one
        if (diff[`HUFF_COEF_W-1]) begin
            mag = mag_bits_t'(diff - 16'sd1) & mask;
        end else begin
            mag = mag_bits_t'(diff) & mask;
        end
    end

    always_ff @(posedge clock) begin
        idx1      <= fetch_idx;
        dec_index <= idx1;
        dec_cat   <= cat;
        dec_mag   <= mag;
    end

    // host may only start a block once the fetch side has drained
    assert property (@(posedge clock) disable iff (nreset)
        start |-> (state == st_idle) && !v1 && !dec_valid)
        else $error("start seen while a block is still being fetched");

endmodule

//--- hw/run_length_coder.sv
`timescale 1ns/10ps
`include "huff_defs.svh"

module run_length_coder
    import huff_pkg::*;
(
    input  logic      clock,
    input  logic      nreset,
    input  logic      dec_valid,
    input  zz_index_t dec_index,
    input  category_t dec_cat,
    input  mag_bits_t dec_mag,
    output logic      rewind,
    output zz_index_t rewind_index,
    output symbol_t   sym,
    output logic      sym_is_dc,
    output logic      rl_emit,
    output category_t rl_cat,
    output mag_bits_t rl_mag,
    output logic      rl_last
);

    run_t run_cnt;
    logic is_dc;
    logic is_ac;
    logic nonzero;
    logic is_eob;
    logic emit;

    always_comb begin
        is_dc   = dec_valid && (dec_index == '0);
        is_ac   = dec_valid && (dec_index != '0);
        nonzero = (dec_cat != '0);
        // more than 15 zeros before a value sends ZRL and refetches after the 16th zero
        rewind       = is_ac && nonzero && (run_cnt >= `HUFF_ZRL_RUN);
        rewind_index = dec_index - zz_index_t'(run_cnt - `HUFF_ZRL_RUN);
        is_eob       = is_ac && !nonzero && (dec_index == `HUFF_LAST_IDX);
        emit         = is_dc || (is_ac && nonzero) || is_eob;
        sym_is_dc    = is_dc;
        if (is_dc) begin
            sym = {4'h0, dec_cat};
        end else if (rewind) begin
            sym = `HUFF_SYM_ZRL;
        end else if (is_ac && nonzero) begin
            sym = {run_cnt[`HUFF_CAT_W-1:0], dec_cat};
        end else begin
            // EOB also parks the lookup on a valid entry when idle
            sym = `HUFF_SYM_EOB;
        end
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            run_cnt <= '0;
            rl_emit <= 1'b0;
            rl_last <= 1'b0;
        end else begin
            if (is_dc || rewind || (is_ac && nonzero)) begin
                run_cnt <= '0;
            end else if (is_ac) begin
                run_cnt <= run_cnt + 1'b1;
            end
            rl_emit <= emit;
            rl_last <= emit && (dec_index == `HUFF_LAST_IDX) && !rewind;
        end
    end

    // ZRL and EOB carry no magnitude bits
    always_ff @(posedge clock) begin
        if (rewind || is_eob) begin
            rl_cat <= '0;
            rl_mag <= '0;
        end else begin
            rl_cat <= dec_cat;
            rl_mag <= dec_mag;
        end
    end

endmodule

//--- hw/huff_code_rom.sv
`timescale 1ns/10ps

module huff_code_rom
    import huff_pkg::*;
(
    input  logic       clock,
    input  symbol_t    sym,
    input  logic       sym_is_dc,
    output huff_code_t rom_code,
    output code_len_t  rom_len
);

    huff_code_t code_nxt;
    code_len_t  len_nxt;
    logic       hit;

    always_comb begin
        code_nxt = '0;
        len_nxt  = '0;
        hit      = 1'b1;
        if (sym_is_dc) begin
            // luminance DC by category
            case (sym)
                8'h00: {code_nxt, len_nxt} = {16'h0000, 5'd2};
                8'h01: {code_nxt, len_nxt} = {16'h0002, 5'd3};
                8'h02: {code_nxt, len_nxt} = {16'h0003, 5'd3};
                8'h03: {code_nxt, len_nxt} = {16'h0004, 5'd3};
                8'h04: {code_nxt, len_nxt} = {16'h0005, 5'd3};
                8'h05: {code_nxt, len_nxt} = {16'h0006, 5'd3};
                8'h06: {code_nxt, len_nxt} = {16'h000e, 5'd4};
                8'h07: {code_nxt, len_nxt} = {16'h001e, 5'd5};
                8'h08: {code_nxt, len_nxt} = {16'h003e, 5'd6};
                8'h09: {code_nxt, len_nxt} = {16'h007e, 5'd7};
                8'h0a: {code_nxt, len_nxt} = {16'h00fe, 5'd8};
                8'h0b: {code_nxt, len_nxt} = {16'h01fe, 5'd9};
                default: hit = 1'b0;
            endcase
        end else begin
            // luminance AC subset with runs 0-3 and categories 1-4 plus EOB and ZRL
            case (sym)
                8'h00: {code_nxt, len_nxt} = {16'h000a, 5'd4};
                8'h01: {code_nxt, len_nxt} = {16'h0000, 5'd2};
                8'h02: {code_nxt, len_nxt} = {16'h0001, 5'd2};
                8'h03: {code_nxt, len_nxt} = {16'h0004, 5'd3};
                8'h04: {code_nxt, len_nxt} = {16'h000b, 5'd4};
                8'h11: {code_nxt, len_nxt} = {16'h000c, 5'd4};
                8'h12: {code_nxt, len_nxt} = {16'h001b, 5'd5};
                8'h13: {code_nxt, len_nxt} = {16'h0079, 5'd7};
                8'h14: {code_nxt, len_nxt} = {16'h01f6, 5'd9};
                8'h21: {code_nxt, len_nxt} = {16'h001c, 5'd5};
                8'h22: {code_nxt, len_nxt} = {16'h00f9, 5'd8};
                8'h23: {code_nxt, len_nxt} = {16'h03f7, 5'd10};
                8'h24: {code_nxt, len_nxt} = {16'h0ff4, 5'd12};
                8'h31: {code_nxt, len_nxt} = {16'h003a, 5'd6};
                8'h32: {code_nxt, len_nxt} = {16'h01f7, 5'd9};
                8'h33: {code_nxt, len_nxt} = {16'h0ff5, 5'd12};
                8'h34: {code_nxt, len_nxt} = {16'hff8f, 5'd16};
                8'hf0: {code_nxt, len_nxt} = {16'h07f9, 5'd11};
                default: hit = 1'b0;
            endcase
        end
    end

    // one cycle read like a block RAM
    always_ff @(posedge clock) begin
        rom_code <= code_nxt;
        rom_len  <= len_nxt;
    end

    // the coder must only form symbols that the tables hold
    assert property (@(posedge clock) !$isunknown({sym_is_dc, sym}) |-> hit)
        else $error("no table entry for symbol %h (dc %b)", sym, sym_is_dc);

endmodule

//--- hw/bit_packer.sv
`timescale 1ns/10ps
`include "huff_defs.svh"

module bit_packer
    import huff_pkg::*;
(
    input  logic       clock,
    input  logic       nreset,
    input  logic       start,
    input  huff_code_t rom_code,
    input  code_len_t  rom_len,
    input  logic       rl_emit,
    input  category_t  rl_cat,
    input  mag_bits_t  rl_mag,
    input  logic       rl_last,
    output logic       word_valid,
    output code_word_t word_data,
    output word_len_t  word_len,
    output logic       busy
);

    code_word_t code_part;
    code_word_t mag_part;
    word_len_t  len_nxt;
    logic       last_q;

    // code left-justified, magnitude bits right behind it
    always_comb begin
        len_nxt   = word_len_t'(rom_len) + word_len_t'(rl_cat);
        code_part = code_word_t'(rom_code) << (`HUFF_WORD_W - rom_len);
        mag_part  = code_word_t'(rl_mag) << (`HUFF_WORD_W - len_nxt);
    end

    always_ff @(posedge clock) begin
        word_data <= code_part | mag_part;
        word_len  <= len_nxt;
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            word_valid <= 1'b0;
            last_q     <= 1'b0;
            busy       <= 1'b0;
        end else begin
            word_valid <= rl_emit;
            last_q     <= rl_emit && rl_last;
            // busy drops the cycle after the final word is out
            if (start) begin
                busy <= 1'b1;
            end else if (last_q) begin
                busy <= 1'b0;
            end
        end
    end

    assert property (@(posedge clock) disable iff (nreset)
        word_valid |-> (word_len <= `HUFF_WORD_W))
        else $error("packed word length %0d exceeds output width", word_len);

endmodule

//--- hw/jpeg_huff_encoder.sv
`timescale 1ns/10ps

module jpeg_huff_encoder
    import huff_pkg::*;
(
    input  logic       clock,
    input  logic       nreset,
    input  logic       start,
    output zz_index_t  fetch_addr,
    input  coef_t      coef_in,
    output logic       word_valid,
    output code_word_t word_data,
    output word_len_t  word_len,
    output logic       busy
);

    //////////////////////////////
    // stage links
    logic       rewind;
    zz_index_t  rewind_index;
    logic       dec_valid;
    zz_index_t  dec_index;
    category_t  dec_cat;
    mag_bits_t  dec_mag;
    symbol_t    sym;
    logic       sym_is_dc;
    logic       rl_emit;
    category_t  rl_cat;
    mag_bits_t  rl_mag;
    logic       rl_last;
    huff_code_t rom_code;
    code_len_t  rom_len;

    coef_decoder u_coef_decoder (
        .clock        (clock),
        .nreset       (nreset),
        .start        (start),
        .rewind       (rewind),
        .rewind_index (rewind_index),
        .coef_in      (coef_in),
        .fetch_addr   (fetch_addr),
        .dec_valid    (dec_valid),
        .dec_index    (dec_index),
        .dec_cat      (dec_cat),
        .dec_mag      (dec_mag),
        .fetch_done   ()
    );

    run_length_coder u_run_length_coder (
        .clock        (clock),
        .nreset       (nreset),
        .dec_valid    (dec_valid),
        .dec_index    (dec_index),
        .dec_cat      (dec_cat),
        .dec_mag      (dec_mag),
        .rewind       (rewind),
        .rewind_index (rewind_index),
        .sym          (sym),
        .sym_is_dc    (sym_is_dc),
        .rl_emit      (rl_emit),
        .rl_cat       (rl_cat),
        .rl_mag       (rl_mag),
        .rl_last      (rl_last)
    );

    huff_code_rom u_huff_code_rom (
        .clock     (clock),
        .sym       (sym),
        .sym_is_dc (sym_is_dc),
        .rom_code  (rom_code),
        .rom_len   (rom_len)
    );

    bit_packer u_bit_packer (
        .clock      (clock),
        .nreset     (nreset),
        .start      (start),
        .rom_code   (rom_code),
        .rom_len    (rom_len),
        .rl_emit    (rl_emit),
        .rl_cat     (rl_cat),
        .rl_mag     (rl_mag),
        .rl_last    (rl_last),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_len   (word_len),
        .busy       (busy)
    );

endmodule

//--- testbench/tb_jpeg_huff_encoder.sv
`timescale 1ns/10ps

module tb_jpeg_huff_encoder
    import huff_pkg::*;
();

    localparam int NUM_BLOCKS      = 10;
    localparam int MAX_PAIRS       = 64;
    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int BLOCK_CYCLES    = 200;
    localparam int WATCHDOG_CYCLES = NUM_BLOCKS * BLOCK_CYCLES + 2 * RESET_CYCLES;
    localparam int EOB_CODE        = 'h00a;
    localparam int EOB_LEN         = 4;
    localparam int ZRL_CODE        = 'h7f9;
    localparam int ZRL_LEN         = 11;

    logic       clock;
    logic       nreset;
    logic       start;
    zz_index_t  fetch_addr;
    coef_t      coef_in;
    logic       word_valid;
    code_word_t word_data;
    word_len_t  word_len;
    logic       busy;

    // standard luminance DC table by category
    int dc_code [12] = '{'h000, 'h002, 'h003, 'h004, 'h005, 'h006,
                         'h00e, 'h01e, 'h03e, 'h07e, 'h0fe, 'h1fe};
    int dc_len  [12] = '{2, 3, 3, 3, 3, 3, 4, 5, 6, 7, 8, 9};
    // luminance AC subset indexed by run*4 + category-1
    int ac_code [16] = '{'h0000, 'h0001, 'h0004, 'h000b,
                         'h000c, 'h001b, 'h0079, 'h01f6,
                         'h001c, 'h00f9, 'h03f7, 'h0ff4,
                         'h003a, 'h01f7, 'h0ff5, 'hff8f};
    int ac_len  [16] = '{2, 2, 3, 4, 4, 5, 7, 9, 5, 8, 10, 12, 6, 9, 12, 16};

    // stimulus table of nonzero (index, value) pairs per block
    int tab_idx   [NUM_BLOCKS][MAX_PAIRS];
    int tab_val   [NUM_BLOCKS][MAX_PAIRS];
    int tab_n     [NUM_BLOCKS];
    bit tab_reset [NUM_BLOCKS];

    coef_t      coef_mem [64];
    code_word_t exp_data [$];
    word_len_t  exp_len  [$];
    int         dc_pred;
    int         words_seen;
    int         words_expected;

    jpeg_huff_encoder u_dut (
        .clock      (clock),
        .nreset     (nreset),
        .start      (start),
        .fetch_addr (fetch_addr),
        .coef_in    (coef_in),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_len   (word_len),
        .busy       (busy)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // registered coefficient memory with a one cycle read
    always @(posedge clock) begin
        coef_in <= #1 coef_mem[fetch_addr];
    end

    //////////////////////////////
    // checks
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input code_word_t got_data, input word_len_t got_len,
                              input code_word_t want_data, input word_len_t want_len);
        if (got_data !== want_data || got_len !== want_len) begin
            stop_on_error($sformatf("mismatch at %0t: word %h len %0d, expected %h len %0d",
                                    $time, got_data, got_len, want_data, want_len));
        end
    endtask

    task automatic check_bit(input logic got, input logic want, input string what);
        if (got !== want) begin
            stop_on_error($sformatf("mismatch at %0t: %s is %b, expected %b",
                                    $time, what, got, want));
        end
    endtask

    task automatic check_busy(input int got_count, input int want_count, input int b);
        if (got_count != want_count) begin
            stop_on_error($sformatf("block %0d finished after %0d words but %0d were expected",
                                    b, got_count, want_count));
        end
    endtask

    // every emitted word is taken in order
    always @(negedge clock) begin
        if (!nreset && word_valid) begin
            if (exp_data.size() == 0) begin
                stop_on_error($sformatf("extra word %h came out at %0t", word_data, $time));
            end else begin
                check_word(word_data, word_len, exp_data.pop_front(), exp_len.pop_front());
                words_seen++;
            end
        end
    end

    //////////////////////////////
    // reference model
    function automatic int category_of(input int v);
        int a;
        int c;
        a = (v < 0) ? -v : v;
        c = 0;
        while (a > 0) begin
            c++;
            a = a >> 1;
        end
        return c;
    endfunction

    function automatic int mag_bits_of(input int v, input int c);
        int m;
        m = (v < 0) ? v - 1 : v;
        return m & ((1 << c) - 1);
    endfunction

    task automatic push_word(input int code, input int len, input int c, input int m);
        code_word_t w;
        w = code_word_t'(code) << (32 - len);
        w = w | (code_word_t'(m) << (32 - len - c));
        exp_data.push_back(w);
        exp_len.push_back(word_len_t'(len + c));
        words_expected++;
    endtask

    task automatic build_expected();
        int diff;
        int run;
        int v;
        int c;
        int k;
        words_expected = 0;
        diff = int'(coef_mem[0]) - dc_pred;
        dc_pred = int'(coef_mem[0]);
        c = category_of(diff);
        push_word(dc_code[c], dc_len[c], c, mag_bits_of(diff, c));
        run = 0;
        for (k = 1; k < 64; k++) begin
            v = int'(coef_mem[k]);
            if (v == 0) begin
                run++;
            end else begin
                // runs above 15 are split by ZRL words
                while (run > 15) begin
                    push_word(ZRL_CODE, ZRL_LEN, 0, 0);
                    run = run - 16;
                end
                c = category_of(v);
                push_word(ac_code[run * 4 + c - 1], ac_len[run * 4 + c - 1], c,
                          mag_bits_of(v, c));
                run = 0;
            end
        end
        if (run > 0) begin
            push_word(EOB_CODE, EOB_LEN, 0, 0);
        end
    endtask

    //////////////////////////////
    // stimulus
    task automatic add_pair(input int b, input int idx, input int val);
        tab_idx[b][tab_n[b]] = idx;
        tab_val[b][tab_n[b]] = val;
        tab_n[b]++;
    endtask

    task automatic load_table();
        int b;
        int pos;
        int gap;
        int val;
        for (b = 0; b < NUM_BLOCKS; b++) begin
            tab_n[b]     = 0;
            tab_reset[b] = 1'b0;
        end
        // block 0 stays all zero
        add_pair(1, 0, 5);
        add_pair(2, 0, 2);
        // mixed signs at runs 0 to 3
        add_pair(3, 0, 2);
        add_pair(3, 1, 3);
        add_pair(3, 2, -2);
        add_pair(3, 4, 7);
        add_pair(3, 7, -15);
        add_pair(3, 11, 1);
        add_pair(3, 12, -4);
        add_pair(3, 14, 9);
        add_pair(3, 18, -1);
        // 19 zeros, then 33 zeros
        add_pair(4, 0, 2);
        add_pair(4, 20, 1);
        add_pair(5, 0, -6);
        add_pair(5, 34, -3);
        // three ZRLs and a nonzero last coefficient
        add_pair(6, 0, 3);
        add_pair(6, 49, 5);
        add_pair(6, 52, -6);
        add_pair(6, 56, 2);
        add_pair(6, 60, -11);
        add_pair(6, 63, 1);
        tab_reset[7] = 1'b1;
        add_pair(7, 0, 7);
        add_pair(7, 1, 1);
        add_pair(7, 3, -1);
        for (b = 8; b < NUM_BLOCKS; b++) begin
            add_pair(b, 0, int'($urandom_range(1000)) - 500);
            pos = int'($urandom_range(3)) + 1;
            while (pos < 64) begin
                val = int'($urandom_range(15, 1));
                if ($urandom_range(1) == 1) begin
                    val = -val;
                end
                add_pair(b, pos, val);
                gap = int'($urandom_range(3));
                if ($urandom_range(5) == 0) begin
                    gap = gap + 16;
                end
                pos = pos + gap + 1;
            end
        end
    endtask

    task automatic fill_memory(input int b);
        int k;
        for (k = 0; k < 64; k++) begin
            coef_mem[k] = '0;
        end
        for (k = 0; k < tab_n[b]; k++) begin
            coef_mem[tab_idx[b][k]] = coef_t'(tab_val[b][k]);
        end
    endtask

    task automatic apply_reset();
        @(posedge clock);
        #1 nreset = 1'b1;
        start = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 nreset = 1'b0;
        dc_pred = 0;
        @(negedge clock);
        check_bit(word_valid, 1'b0, "word_valid after reset");
        check_bit(busy, 1'b0, "busy after reset");
    endtask

    task automatic run_block(input int b);
        int waited;
        words_seen = 0;
        @(posedge clock);
        #1 start = 1'b1;
        @(posedge clock);
        #1 start = 1'b0;
        @(negedge clock);
        check_bit(busy, 1'b1, "busy after start");
        waited = 0;
        while (busy && waited < BLOCK_CYCLES) begin
            @(negedge clock);
            waited++;
        end
        if (busy) begin
            stop_on_error($sformatf("block %0d still busy after %0d cycles", b, BLOCK_CYCLES));
        end
        check_busy(words_seen, words_expected, b);
    endtask

    //////////////////////////////
    // main sequence
    initial begin
        void'($urandom(1213));
        clock   = 1'b0;
        nreset  = 1'b1;
        start   = 1'b0;
        coef_in = '0;
        dc_pred = 0;
        load_table();
        apply_reset();
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            if (tab_reset[b]) begin
                apply_reset();
            end
            fill_memory(b);
            build_expected();
            run_block(b);
        end
        if (exp_data.size() != 0) begin
            stop_on_error($sformatf("%0d expected words never came out", exp_data.size()));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error($sformatf("run did not finish within %0d cycles", WATCHDOG_CYCLES));
    end

endmodule

//--- vlog.f
+incdir+hw
hw/huff_pkg.sv
hw/coef_decoder.sv
hw/run_length_coder.sv
hw/huff_code_rom.sv
hw/bit_packer.sv
hw/jpeg_huff_encoder.sv
testbench/tb_jpeg_huff_encoder.sv
